// File: hw/tpu_params.svh
// TPU configuration macros
`ifndef TPU_PARAMS_SVH
`define TPU_PARAMS_SVH

// Buffer between front end and scalar unit
`define TPU_BUFF_DEPTH	8

// Vector unit
`define TPU_LANES		4

// Datapath and instruction widths
`define TPU_DATA_W		16
`define TPU_INSTR_W		16

// Host issue number and thread id
`define TPU_ISSUE_W		4
`define TPU_ID_W		4

`endif

// File: hw/tpu_pkg.sv
// TPU shared types
`include "tpu_params.svh"

package tpu_pkg;

	typedef logic [`TPU_DATA_W-1:0]				data_t;
	typedef logic [`TPU_INSTR_W-1:0]			instr_t;		// {opcode, reg, imm}
	typedef logic [`TPU_ISSUE_W-1:0]			issue_no_t;
	typedef logic [`TPU_ID_W-1:0]				id_t;
	typedef logic [`TPU_ID_W+`TPU_ISSUE_W-1:0]	tag_t;			// {id, issue_no}
	typedef logic [`TPU_LANES-1:0]				lane_mask_t;

	typedef enum logic [3:0] {
		NOP		= 4'h0,
		LDI		= 4'h1,		// reg = zext(imm)
		ADD		= 4'h2,		// reg = reg + r[imm[1:0]]
		MASK	= 4'h3,		// Lane mask from low imm bits
		VBCAST	= 4'h4,
		VADD	= 4'h5,
		VSUM	= 4'h6,		// reg = sum of every lane
		OUT		= 4'h7,
		STOP	= 4'h8
	} opcode_t;

	typedef enum logic [1:0] {V_NONE, V_BCAST, V_ADD, V_SUM} v_cmd_t;

	typedef enum logic [1:0] {S_IDLE, S_EXEC, S_WAIT_SUM} s_state_t;

	// Instruction field extraction
	function automatic opcode_t instr_opcode(input instr_t i);
		return opcode_t'(i[`TPU_INSTR_W-1 -: 4]);
	endfunction

	function automatic logic [1:0] instr_reg(input instr_t i);
		return i[`TPU_INSTR_W-5 -: 2];
	endfunction

	function automatic logic [`TPU_INSTR_W-7:0] instr_imm(input instr_t i);
		return i[`TPU_INSTR_W-7:0];
	endfunction

endpackage

// File: hw/ring_buff.sv
// Circular FIFO
module ring_buff #(
	parameter int DEPTH = 8,
	parameter int WIDTH = 16
) (
	input  logic				clock,
	input  logic				rst,
	input  logic				we,
	input  logic				re,
	input  logic [WIDTH-1:0]	wdata,
	output logic [WIDTH-1:0]	rdata,
	output logic				full,
	output logic				empty
);

	localparam int AW = $clog2(DEPTH);

	logic [WIDTH-1:0]	mem [DEPTH];
	logic [AW:0]		wr_ptr;			// MSB is the wrap bit
	logic [AW:0]		rd_ptr;

	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
	assign rdata = mem[rd_ptr[AW-1:0]];			// Head entry

	always_ff @(posedge clock) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (we && !full)
				wr_ptr <= wr_ptr + 1'b1;
			if (re && !empty)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (we && !full)
			mem[wr_ptr[AW-1:0]] <= wdata;
	end

endmodule

// File: hw/front_end.sv
// TPU request front end
module front_end (
	input  logic				clock,
	input  logic				rst,
	input  logic				req,
	input  tpu_pkg::issue_no_t	issue_no,
	input  tpu_pkg::instr_t		instr,
	input  logic				full,
	output logic				we,
	output tpu_pkg::instr_t		wr_instr,
	output tpu_pkg::tag_t		wr_tag,
	output logic				nack
);

	import tpu_pkg::*;

	logic		req_q;
	issue_no_t	issue_q;
	id_t		thread_id;

	//////////////////////////////////////////////////////////////////////
	// Request register
	always_ff @(posedge clock) begin
		if (rst)
			req_q <= 1'b0;
		else
			req_q <= req;
	end

	always_ff @(posedge clock) begin
		if (req) begin
			wr_instr <= instr;
			issue_q  <= issue_no;
		end
	end

	// Accept or refuse against the current buffer state
	assign we     = req_q & ~full;
	assign nack   = req_q & full;
	assign wr_tag = {thread_id, issue_q};

	//////////////////////////////////////////////////////////////////////
	// Thread numbering
	always_ff @(posedge clock) begin
		if (rst)
			thread_id <= '0;
		else if (we && instr_opcode(wr_instr) == STOP)
			thread_id <= thread_id + 1'b1;		// Next thread after STOP
	end

endmodule

// File: hw/scalar_unit.sv
// TPU scalar control unit
`include "tpu_params.svh"

module scalar_unit (
	input  logic				clock,
	input  logic				rst,
	input  logic				en_exe,
	input  logic				empty,
	input  tpu_pkg::instr_t		instr,
	input  tpu_pkg::tag_t		tag,
	output logic				re,
	output tpu_pkg::v_cmd_t		v_cmd,
	output tpu_pkg::lane_mask_t	lane_mask,
	output tpu_pkg::data_t		v_operand,
	input  logic				commit_req,
	input  tpu_pkg::data_t		sum_data,
	output logic				commit_grant,
	output logic				res_valid,
	output tpu_pkg::data_t		res_data,
	output tpu_pkg::id_t		res_id,
	output logic				term,
	output tpu_pkg::issue_no_t	term_issue_no
);

	import tpu_pkg::*;

	localparam int NUM_REGS = 4;

	s_state_t					state;
	instr_t						ir;			// Instruction in execution
	tag_t						ir_tag;
	data_t						regs [NUM_REGS];
	opcode_t					opc;
	logic [1:0]					rd;
	logic [`TPU_INSTR_W-7:0]	imm;
	logic						slot_free;

	assign opc = instr_opcode(ir);
	assign rd  = instr_reg(ir);
	assign imm = instr_imm(ir);

	//////////////////////////////////////////////////////////////////////
	// Issue control
	always_comb begin
		case (state)
			S_IDLE:		slot_free = 1'b1;
			S_EXEC:		slot_free = (opc != VSUM);		// VSUM holds the slot
			S_WAIT_SUM:	slot_free = commit_req;
			default:	slot_free = 1'b0;
		endcase
	end

	assign re           = slot_free & en_exe & ~empty;
	assign commit_grant = (state == S_WAIT_SUM) & commit_req;

	always_ff @(posedge clock) begin
		if (re) begin
			ir     <= instr;
			ir_tag <= tag;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// FSM, register file and strobes
	always_ff @(posedge clock) begin
		if (rst) begin
			state     <= S_IDLE;
			v_cmd     <= V_NONE;
			res_valid <= 1'b0;
			term      <= 1'b0;
			lane_mask <= '1;
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else begin
			v_cmd     <= V_NONE;
			res_valid <= 1'b0;
			term      <= 1'b0;
			case (state)
				S_IDLE: begin
					if (re)
						state <= S_EXEC;
				end
				S_EXEC: begin
					case (opc)
						LDI:	regs[rd] <= data_t'(imm);
						ADD:	regs[rd] <= regs[rd] + regs[imm[1:0]];
						MASK:	lane_mask <= imm[`TPU_LANES-1:0];
						VBCAST:	v_cmd <= V_BCAST;
						VADD:	v_cmd <= V_ADD;
						VSUM:	v_cmd <= V_SUM;
						OUT:	res_valid <= 1'b1;
						STOP: begin
							term      <= 1'b1;
							lane_mask <= '1;			// Fresh state for next thread
							for (int i = 0; i < NUM_REGS; i++)
								regs[i] <= '0;
						end
						default: ;
					endcase
					if (opc == VSUM)
						state <= S_WAIT_SUM;
					else if (!re)
						state <= S_IDLE;
				end
				S_WAIT_SUM: begin
					if (commit_req) begin
						regs[rd] <= sum_data;		// Granted this cycle
						state    <= re ? S_EXEC : S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// Operand and result payloads
	always_ff @(posedge clock) begin
		if (state == S_EXEC) begin
			v_operand     <= regs[rd];
			res_data      <= regs[rd];
			res_id        <= ir_tag[`TPU_ISSUE_W +: `TPU_ID_W];
			term_issue_no <= ir_tag[`TPU_ISSUE_W-1:0];
		end
	end

endmodule

// File: hw/vector_unit.sv
// TPU vector lane unit
`include "tpu_params.svh"

module vector_unit (
	input  logic				clock,
	input  logic				rst,
	input  tpu_pkg::v_cmd_t		v_cmd,
	input  tpu_pkg::lane_mask_t	lane_mask,
	input  tpu_pkg::data_t		v_operand,
	input  logic				commit_grant,
	output logic				commit_req,
	output tpu_pkg::data_t		sum_data
);

	import tpu_pkg::*;

	localparam int LANES = `TPU_LANES;
	localparam int PAIRS = LANES / 2;

	data_t	lanes [LANES];
	data_t	pair_sum [PAIRS];
	data_t	lane_sum;

	//////////////////////////////////////////////////////////////////////
	// Reduction tree over all lanes regardless of the mask
	for (genvar j = 0; j < PAIRS; j++) begin : g_pair
		assign pair_sum[j] = lanes[2*j] + lanes[2*j+1];		// First level
	end

	always_comb begin
		lane_sum = '0;
		for (int j = 0; j < PAIRS; j++)
			lane_sum = lane_sum + pair_sum[j];
	end

	//////////////////////////////////////////////////////////////////////
	// Lane accumulators
	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < LANES; i++)
				lanes[i] <= '0;
		end else begin
			for (int i = 0; i < LANES; i++) begin
				if (lane_mask[i]) begin
					case (v_cmd)
						V_BCAST:	lanes[i] <= v_operand;
						V_ADD:		lanes[i] <= lanes[i] + v_operand;	// Wraps at 16 bits
						default: ;
					endcase
				end
			end
		end
	end

	// Commit handshake back to the scalar unit
	always_ff @(posedge clock) begin
		if (rst)
			commit_req <= 1'b0;
		else if (v_cmd == V_SUM)
			commit_req <= 1'b1;
		else if (commit_grant)
			commit_req <= 1'b0;
	end

	always_ff @(posedge clock) begin
		if (v_cmd == V_SUM)
			sum_data <= lane_sum;
	end

endmodule

// File: hw/tpu.sv
// Thread processing unit top
`include "tpu_params.svh"

module tpu (
	input  logic				clock,
	input  logic				rst,
	input  logic				en_exe,
	input  logic				req,
	input  tpu_pkg::issue_no_t	issue_no,
	input  tpu_pkg::instr_t		instr,
	output logic				nack,
	output logic				res_valid,
	output tpu_pkg::data_t		res_data,
	output tpu_pkg::id_t		res_id,
	output logic				term,
	output tpu_pkg::issue_no_t	term_issue_no
);

	import tpu_pkg::*;

	logic		buff_we;
	logic		buff_re;
	logic		buff_full;
	logic		buff_empty;
	instr_t		wr_instr;
	tag_t		wr_tag;
	instr_t		head_instr;
	tag_t		head_tag;
	v_cmd_t		v_cmd;
	lane_mask_t	lane_mask;
	data_t		v_operand;
	logic		commit_req;
	logic		commit_grant;
	data_t		sum_data;

	//////////////////////////////////////////////////////////////////////
	// Front end and buffers
	front_end u_front_end (
		.clock		(clock),
		.rst		(rst),
		.req		(req),
		.issue_no	(issue_no),
		.instr		(instr),
		.full		(buff_full),
		.we			(buff_we),
		.wr_instr	(wr_instr),
		.wr_tag		(wr_tag),
		.nack		(nack)
	);

	ring_buff #(
		.DEPTH	(`TPU_BUFF_DEPTH),
		.WIDTH	(`TPU_INSTR_W)
	) instr_buff (
		.clock	(clock),
		.rst	(rst),
		.we		(buff_we),
		.re		(buff_re),
		.wdata	(wr_instr),
		.rdata	(head_instr),
		.full	(buff_full),
		.empty	(buff_empty)
	);

	// Tags move in lockstep with instr_buff
	ring_buff #(
		.DEPTH	(`TPU_BUFF_DEPTH),
		.WIDTH	(`TPU_ID_W + `TPU_ISSUE_W)
	) id_buff (
		.clock	(clock),
		.rst	(rst),
		.we		(buff_we),
		.re		(buff_re),
		.wdata	(wr_tag),
		.rdata	(head_tag),
		.full	(),
		.empty	()
	);

	//////////////////////////////////////////////////////////////////////
	// Execution units
	scalar_unit u_scalar_unit (
		.clock			(clock),
		.rst			(rst),
		.en_exe			(en_exe),
		.empty			(buff_empty),
		.instr			(head_instr),
		.tag			(head_tag),
		.re				(buff_re),
		.v_cmd			(v_cmd),
		.lane_mask		(lane_mask),
		.v_operand		(v_operand),
		.commit_req		(commit_req),
		.sum_data		(sum_data),
		.commit_grant	(commit_grant),
		.res_valid		(res_valid),
		.res_data		(res_data),
		.res_id			(res_id),
		.term			(term),
		.term_issue_no	(term_issue_no)
	);

	vector_unit u_vector_unit (
		.clock			(clock),
		.rst			(rst),
		.v_cmd			(v_cmd),
		.lane_mask		(lane_mask),
		.v_operand		(v_operand),
		.commit_grant	(commit_grant),
		.commit_req		(commit_req),
		.sum_data		(sum_data)
	);

endmodule

// File: testbench/tpu_checker.sv
// TPU response checker
`include "tpu_params.svh"

module tpu_checker (
	input  logic				clock,
	input  logic				rst,
	input  logic				en_exe,
	input  logic				req,
	input  tpu_pkg::issue_no_t	issue_no,
	input  tpu_pkg::instr_t		instr,
	input  logic				nack,
	input  logic				res_valid,
	input  tpu_pkg::data_t		res_data,
	input  tpu_pkg::id_t		res_id,
	input  logic				term,
	input  tpu_pkg::issue_no_t	term_issue_no,
	input  logic [8*12-1:0]		test_name,
	output logic				idle,
	output int					res_errors,
	output int					term_errors,
	output int					nack_errors
);

	timeunit 1ns;
	timeprecision 1ps;

	import tpu_pkg::*;

	localparam int NAME_W = 8*12;
	localparam int DEPTH  = `TPU_BUFF_DEPTH;
	localparam int LANES  = `TPU_LANES;

	typedef struct packed {
		logic [NAME_W-1:0]	name;
		id_t				id;
		issue_no_t			issue;
		instr_t				instr;
	} entry_t;

	typedef struct packed {
		logic [NAME_W-1:0]	name;
		id_t				id;
		data_t				data;
	} result_t;

	entry_t		buff_q [$];		// Buffer occupancy model
	result_t	res_q [$];		// Results still to come
	entry_t		term_q [$];		// STOPs still to terminate
	data_t		m_regs [4];
	data_t		m_lanes [LANES];
	lane_mask_t	m_mask;
	id_t		m_thread;
	int			busy;			// Issue slots blocked after a VSUM
	logic		req_q;
	entry_t		pend;			// Request seen one cycle ago

	//////////////////////////////////////////////////////////////////////
	// Instruction rules
	task automatic execute(input entry_t e);
		opcode_t	op;
		logic [1:0]	r;
		logic [9:0]	imm;
		data_t		sum;
		result_t	res;
		op  = opcode_t'(e.instr[15:12]);
		r   = e.instr[11:10];
		imm = e.instr[9:0];
		sum = '0;
		case (op)
			LDI:	m_regs[r] = data_t'(imm);
			ADD:	m_regs[r] = m_regs[r] + m_regs[imm[1:0]];
			MASK:	m_mask = imm[LANES-1:0];
			VBCAST, VADD: begin
				for (int i = 0; i < LANES; i++)
					if (m_mask[i])
						m_lanes[i] = (op == VADD) ? m_lanes[i] + m_regs[r] : m_regs[r];
			end
			VSUM: begin
				for (int i = 0; i < LANES; i++)
					sum = sum + m_lanes[i];		// Mask ignored
				m_regs[r] = sum;
				busy      = 2;
			end
			OUT: begin
				res.name = e.name;
				res.id   = e.id;
				res.data = m_regs[r];
				res_q.push_back(res);
			end
			STOP: begin
				term_q.push_back(e);
				m_mask = '1;
				for (int i = 0; i < 4; i++)
					m_regs[i] = '0;
			end
			default: ;
		endcase
	endtask

	//////////////////////////////////////////////////////////////////////
	// Cycle model and comparison
	always @(posedge clock) begin
		logic		full_m;
		logic		pop;
		result_t	exp_res;
		entry_t		exp_term;
		if (rst) begin
			buff_q.delete();
			res_q.delete();
			term_q.delete();
			for (int i = 0; i < 4; i++)
				m_regs[i] = '0;
			for (int i = 0; i < LANES; i++)
				m_lanes[i] = '0;
			m_mask      = '1;
			m_thread    = '0;
			busy        = 0;
			req_q       = 1'b0;
			res_errors  = 0;
			term_errors = 0;
			nack_errors = 0;
		end else begin
			full_m = (buff_q.size() == DEPTH);
			pop    = (busy == 0) && en_exe && (buff_q.size() != 0);
			if (nack !== (req_q && full_m)) begin
				nack_errors++;
				$display("Mismatch %0s: nack expected %b, actual %b", pend.name,
					req_q && full_m, nack);
			end
			if (busy > 0)
				busy--;
			if (pop)
				execute(buff_q.pop_front());
			if (req_q && !full_m) begin
				pend.id = m_thread;
				buff_q.push_back(pend);
				if (opcode_t'(pend.instr[15:12]) == STOP)
					m_thread++;					// Next thread id
			end
			req_q      = req;
			pend.name  = test_name;
			pend.issue = issue_no;
			pend.instr = instr;

			if (res_valid) begin
				if (res_q.size() == 0) begin
					res_errors++;
					$display("Result strobe in test %0s when no OUT was pending", test_name);
				end else begin
					exp_res = res_q.pop_front();
					if (res_data !== exp_res.data) begin
						res_errors++;
						$display("Mismatch %0s: res_data expected %h, actual %h",
							exp_res.name, exp_res.data, res_data);
					end
					if (res_id !== exp_res.id) begin
						res_errors++;
						$display("Mismatch %0s: res_id expected %h, actual %h",
							exp_res.name, exp_res.id, res_id);
					end
				end
			end

			if (term) begin
				if (term_q.size() == 0) begin
					term_errors++;
					$display("Termination strobe in test %0s when no STOP was pending",
						test_name);
				end else begin
					exp_term = term_q.pop_front();
					if (term_issue_no !== exp_term.issue) begin
						term_errors++;
						$display("Mismatch %0s: term_issue_no expected %h, actual %h",
							exp_term.name, exp_term.issue, term_issue_no);
					end
				end
			end
		end
		idle <= !rst && !req_q && (busy == 0) && (buff_q.size() == 0)
			&& (res_q.size() == 0) && (term_q.size() == 0);
	end

endmodule

// File: testbench/tb_tpu.sv
// TPU testbench
module tb_tpu;

	timeunit 1ns;
	timeprecision 1ps;

	import tpu_pkg::*;

	localparam int NAME_W     = 8*12;
	localparam int RANDOM_LEN = 40;

	typedef struct packed {
		logic [NAME_W-1:0]	name;
		logic				en_exe;
		instr_t				instr;
		issue_no_t			issue_no;
	} row_t;

	logic				clock = 1'b0;
	logic				rst;
	logic				en_exe;
	logic				req;
	issue_no_t			issue_no;
	instr_t				instr;
	logic				nack;
	logic				res_valid;
	data_t				res_data;
	id_t				res_id;
	logic				term;
	issue_no_t			term_issue_no;
	logic [NAME_W-1:0]	test_name;
	logic				idle;
	int					res_errors;
	int					term_errors;
	int					nack_errors;
	logic				table_ready = 1'b0;
	row_t				rows [$];

	always #2 clock = ~clock;		// 4 ns period

	tpu UUT (
		.clock			(clock),
		.rst			(rst),
		.en_exe			(en_exe),
		.req			(req),
		.issue_no		(issue_no),
		.instr			(instr),
		.nack			(nack),
		.res_valid		(res_valid),
		.res_data		(res_data),
		.res_id			(res_id),
		.term			(term),
		.term_issue_no	(term_issue_no)
	);

	tpu_checker u_checker (
		.clock			(clock),
		.rst			(rst),
		.en_exe			(en_exe),
		.req			(req),
		.issue_no		(issue_no),
		.instr			(instr),
		.nack			(nack),
		.res_valid		(res_valid),
		.res_data		(res_data),
		.res_id			(res_id),
		.term			(term),
		.term_issue_no	(term_issue_no),
		.test_name		(test_name),
		.idle			(idle),
		.res_errors		(res_errors),
		.term_errors	(term_errors),
		.nack_errors	(nack_errors)
	);

	//////////////////////////////////////////////////////////////////////
	// Stimulus table
	task automatic add_row(input logic [NAME_W-1:0] name, input logic en,
			input opcode_t op, input logic [1:0] r, input logic [9:0] imm);
		row_t row;
		row.name     = name;
		row.en_exe   = en;
		row.instr    = {op, r, imm};
		row.issue_no = issue_no_t'(rows.size());
		rows.push_back(row);
	endtask

	task automatic build_table();
		opcode_t	op;
		logic		en;
		logic [1:0]	r;
		logic [9:0]	imm;
		add_row("ldi_add_out", 1, LDI, 0, 5);
		add_row("ldi_add_out", 1, LDI, 1, 7);
		add_row("ldi_add_out", 1, ADD, 0, 1);
		add_row("ldi_add_out", 1, OUT, 0, 0);			// 12
		add_row("ldi_add_out", 1, LDI, 2, 1023);
		add_row("ldi_add_out", 1, ADD, 2, 2);
		add_row("ldi_add_out", 1, OUT, 2, 0);			// 2046
		add_row("ldi_add_out", 1, STOP, 0, 0);
		add_row("vector", 1, MASK, 0, 15);
		add_row("vector", 1, LDI, 0, 3);
		add_row("vector", 1, VBCAST, 0, 0);
		add_row("vector", 1, MASK, 0, 5);
		add_row("vector", 1, LDI, 1, 10);
		add_row("vector", 1, VADD, 1, 0);
		add_row("vector", 1, VSUM, 2, 0);
		add_row("vector", 1, OUT, 2, 0);				// 13+3+13+3
		add_row("vector", 1, MASK, 0, 10);
		add_row("vector", 1, VADD, 1, 0);
		add_row("vector", 1, VSUM, 3, 0);
		add_row("vector", 1, OUT, 3, 0);
		add_row("vector", 1, STOP, 0, 0);
		// Ninth request finds the buffer full
		add_row("nack_full", 0, LDI, 0, 100);
		add_row("nack_full", 0, LDI, 1, 23);
		add_row("nack_full", 0, ADD, 0, 1);
		add_row("nack_full", 0, OUT, 0, 0);
		add_row("nack_full", 0, VBCAST, 0, 0);
		add_row("nack_full", 0, VSUM, 1, 0);
		add_row("nack_full", 0, OUT, 1, 0);
		add_row("nack_full", 0, STOP, 0, 0);
		add_row("nack_full", 0, OUT, 0, 0);
		add_row("thread_reset", 1, LDI, 1, 9);
		add_row("thread_reset", 1, MASK, 0, 1);
		add_row("thread_reset", 1, STOP, 0, 0);
		add_row("thread_reset", 1, OUT, 1, 0);			// Cleared by STOP
		add_row("thread_reset", 1, LDI, 0, 2);
		add_row("thread_reset", 1, VBCAST, 0, 0);
		add_row("thread_reset", 1, VSUM, 3, 0);
		add_row("thread_reset", 1, OUT, 3, 0);			// Full mask again
		add_row("thread_reset", 1, STOP, 0, 0);
		for (int i = 0; i < RANDOM_LEN; i++) begin
			op  = opcode_t'(4'($urandom % 9));
			en  = ($urandom % 4) != 0;
			r   = 2'($urandom % 4);
			imm = 10'($urandom % 1024);
			if (i == RANDOM_LEN - 1)
				op = STOP;
			add_row("random", en, op, r, imm);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Run control
	task automatic wait_idle();
		@(posedge clock);
		req    <= 1'b0;
		en_exe <= 1'b1;
		@(posedge clock);
		while (!idle)
			@(posedge clock);
	endtask

	task automatic finish_run(input logic timed_out);
		int total;
		total = res_errors + term_errors + nack_errors + (timed_out ? 1 : 0);
		$display("Errors: %0d (results %0d, terminations %0d, nacks %0d, timeouts %0d)",
			total, res_errors, term_errors, nack_errors, timed_out ? 1 : 0);
		if (total == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	endtask

	initial begin
		void'($urandom(32'he5ca));
		rst       = 1'b1;
		en_exe    = 1'b0;
		req       = 1'b0;
		issue_no  = '0;
		instr     = '0;
		test_name = "reset";
		build_table();
		table_ready = 1'b1;
		repeat (5) @(posedge clock);
		rst <= 1'b0;
		for (int i = 0; i < rows.size(); i++) begin
			if (i > 0 && rows[i].name != rows[i-1].name)
				wait_idle();				// Each test starts on an empty buffer
			@(posedge clock);
			req       <= 1'b1;
			en_exe    <= rows[i].en_exe;
			instr     <= rows[i].instr;
			issue_no  <= rows[i].issue_no;
			test_name <= rows[i].name;
		end
		wait_idle();
		finish_run(1'b0);
	end

	// Watchdog
	initial begin
		wait (table_ready);
		repeat (rows.size() * 20) @(posedge clock);
		$display("Timeout: the DUT did not finish the table within %0d cycles",
			rows.size() * 20);
		finish_run(1'b1);
	end

endmodule

// File: sources.f
+incdir+hw
hw/tpu_pkg.sv
hw/ring_buff.sv
hw/front_end.sv
hw/scalar_unit.sv
hw/vector_unit.sv
hw/tpu.sv
testbench/tpu_checker.sv
testbench/tb_tpu.sv

// File: Makefile
SIM      = verilator
TOP      = tb_tpu
FILELIST = sources.f
VFLAGS   = --binary -Wno-fatal --top-module $(TOP)
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
SOURCES  = $(shell grep -v '^+' $(FILELIST)) $(wildcard hw/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(VFLAGS) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)
